// File: verification/uart_cases.txt
// Columns in hex: operation, byte, expected value
// 01 control write/read, 02 transmit, 03 receive, 04 low stop bit, 05 write while busy, 06 unmapped read, 00 end
01 a5 a5
06 10 00
06 fc 00
02 55 55
02 c3 c3
05 3a 7e
03 96 96
04 5b 96
03 01 01
00 00 00

// File: src.f
common/uart_pkg.sv
common/uart_tx_if.sv
hw/uart/uart_tx.sv
hw/uart/uart_rx.sv
hw/uart/uart_regs.sv
hw/apb_uart.sv
verification/apb_uart_props.sv
verification/tb_apb_uart.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the APB UART testbench with Verilator.
# Exits non-zero when the build fails, the run fails or the log reports failures.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_apb_uart -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/Vtb_apb_uart > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
echo "Simulation PASSED"
exit 0

// File: verification/tb_apb_uart.sv
/*
 * Testbench for the APB UART peripheral.
 * Runs the cases in verification/uart_cases.txt, then random bytes from an LFSR.
 * Drives APB and the rx line, captures tx frames at mid-bit, checks registers and irq.
 */

`default_nettype none

module tb_apb_uart;
  import uart_pkg::*;

  localparam int MAX_CASES = 32;
  localparam int RANDOM_ROUNDS = 4;

  logic                  clk;
  logic                  rst_n;
  logic [ADDR_WIDTH-1:0] paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [DATA_WIDTH-1:0] pwdata;
  logic [DATA_WIDTH-1:0] prdata;
  logic                  pready;
  logic                  pslverr;
  logic                  uart_rx;
  logic                  uart_tx;
  logic                  irq;

  logic [DATA_WIDTH-1:0] case_mem [0:3*MAX_CASES-1];
  logic [31:0]           lfsr = 32'hc9c;
  int                    irq_count = 0;
  int                    exp_irq = 0;
  int                    cycle_limit = 0;
  int                    cycles = 0;

  apb_uart apb_uart_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk) begin
    if (irq === 1'b1) irq_count++;
  end

  // Run length guard
  initial begin
    wait (cycle_limit != 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    report_failure("timeout, the run went past its cycle limit");
  end

  // ====================
  // Reporting and checks
  // ====================
  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] got, exp);
    if (got !== exp)
      report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_byte(input string name, input logic [BYTE_WIDTH-1:0] got, exp);
    if (got !== exp)
      report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp)
      report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_byte(output logic [BYTE_WIDTH-1:0] b);
    int k;
    for (k = 0; k < BYTE_WIDTH; k++) begin
      lfsr = lfsr_next(lfsr);
      b[k] = lfsr[0];
    end
  endtask

  function automatic logic [DATA_WIDTH-1:0] to_word(input logic [BYTE_WIDTH-1:0] b);
    return {{(DATA_WIDTH - BYTE_WIDTH){1'b0}}, b};
  endfunction

  // ====================
  // APB and line drivers
  // ====================
  task automatic apb_write(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input logic [ADDR_WIDTH-1:0] addr, output logic [DATA_WIDTH-1:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic check_read(input logic [ADDR_WIDTH-1:0] addr,
                            input logic [DATA_WIDTH-1:0] exp, input string name);
    logic [DATA_WIDTH-1:0] w;
    apb_read(addr, w);
    check_word(name, w, exp);
  endtask

  task automatic wait_status(input int idx);
    logic [DATA_WIDTH-1:0] st;
    int tries;
    st = '0;
    tries = 0;
    while (st[idx] !== 1'b1) begin
      if (tries > 4 * BAUD_DIV)
        report_failure($sformatf("status bit %0d was never set", idx));
      apb_read(REG_STATUS, st);
      tries++;
    end
  endtask

  // Write 1 to clear, then confirm the bit dropped
  task automatic clear_status(input int idx);
    logic [DATA_WIDTH-1:0] m;
    m = '0;
    m[idx] = 1'b1;
    apb_write(REG_STATUS, m);
    apb_read(REG_STATUS, m);
    check_bit("status bit after clear", m[idx], 1'b0);
  endtask

  task automatic check_irq();
    repeat (2) @(posedge clk);
    check_word("irq pulse count", DATA_WIDTH'(irq_count), DATA_WIDTH'(exp_irq));
  endtask

  task automatic capture_frame(output logic [BYTE_WIDTH-1:0] data);
    int waited;
    int k;
    waited = 0;
    while (uart_tx !== 1'b0) begin
      @(negedge clk);
      waited++;
      if (waited > 4 * BAUD_DIV) report_failure("no start bit seen on uart_tx");
    end
    repeat (HALF_BAUD) @(negedge clk);
    check_bit("uart_tx start bit", uart_tx, 1'b0);
    for (k = 0; k < BYTE_WIDTH; k++) begin
      repeat (BAUD_DIV) @(negedge clk);
      data[k] = uart_tx;
    end
    repeat (BAUD_DIV) @(negedge clk);
    check_bit("uart_tx stop bit", uart_tx, 1'b1);
  endtask

  task automatic send_frame(input logic [BYTE_WIDTH-1:0] data, input logic stop);
    logic [9:0] bits;
    int k;
    bits = {stop, data, 1'b0};
    for (k = 0; k < 10; k++) begin
      @(posedge clk);
      uart_rx <= bits[k];
      repeat (BAUD_DIV - 1) @(posedge clk);
    end
    @(posedge clk);
    uart_rx <= 1'b1;
  endtask

  // ====================
  // Case operations
  // ====================
  task automatic do_transmit(input logic [BYTE_WIDTH-1:0] b, e);
    logic [BYTE_WIDTH-1:0] got;
    logic [DATA_WIDTH-1:0] st;
    apb_write(REG_TX_DATA, to_word(b));
    fork
      capture_frame(got);
      begin
        repeat (4 * BAUD_DIV) @(posedge clk);
        apb_read(REG_STATUS, st);
      end
    join
    check_bit("status tx_busy during frame", st[ST_TX_BUSY], 1'b1);
    check_byte("uart_tx byte", got, e);
    wait_status(ST_TX_DONE);
    exp_irq++;
    check_irq();
    clear_status(ST_TX_DONE);
  endtask

  task automatic do_busy_write(input logic [BYTE_WIDTH-1:0] b, e);
    logic [BYTE_WIDTH-1:0] got;
    apb_write(REG_TX_DATA, to_word(b));
    fork
      capture_frame(got);
      begin
        repeat (3 * BAUD_DIV) @(posedge clk);
        apb_write(REG_TX_DATA, to_word(e));
      end
    join
    check_byte("uart_tx byte", got, b);
    // No second frame may follow
    repeat (2 * BAUD_DIV) begin
      @(negedge clk);
      check_bit("uart_tx idle after frame", uart_tx, 1'b1);
    end
    wait_status(ST_TX_DONE);
    exp_irq++;
    check_irq();
    check_read(REG_TX_DATA, to_word(e), "tx data register");
    clear_status(ST_TX_DONE);
  endtask

  task automatic do_receive(input logic [BYTE_WIDTH-1:0] b, e, input logic stop);
    logic [DATA_WIDTH-1:0] st;
    send_frame(b, stop);
    wait_status(stop ? ST_RX_VALID : ST_RX_ERROR);
    exp_irq++;
    check_irq();
    check_read(REG_RX_DATA, to_word(e), "rx data register");
    if (!stop) begin
      apb_read(REG_STATUS, st);
      check_bit("status rx_valid after framing error", st[ST_RX_VALID], 1'b0);
    end
    clear_status(stop ? ST_RX_VALID : ST_RX_ERROR);
  endtask

  initial begin
    int i;
    int frames;
    logic [BYTE_WIDTH-1:0] op;
    logic [BYTE_WIDTH-1:0] b;
    logic [BYTE_WIDTH-1:0] e;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    uart_rx = 1'b1;
    $readmemh("verification/uart_cases.txt", case_mem);

    // Frame count sets the cycle limit
    frames = 2 * RANDOM_ROUNDS;
    i = 0;
    while (i < MAX_CASES && case_mem[3*i] != '0) begin
      if (case_mem[3*i] == 5) frames += 2;
      else if (case_mem[3*i] >= 2 && case_mem[3*i] <= 4) frames += 1;
      i++;
    end
    cycle_limit = frames * 12 * BAUD_DIV + 100 * i + 500;

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    check_read(REG_CONTROL, '0, "control after reset");
    check_read(REG_STATUS, '0, "status after reset");
    check_read(REG_TX_DATA, '0, "tx data after reset");
    check_read(REG_RX_DATA, '0, "rx data after reset");
    @(negedge clk);
    check_bit("uart_tx after reset", uart_tx, 1'b1);
    check_bit("irq after reset", irq, 1'b0);

    i = 0;
    while (i < MAX_CASES && case_mem[3*i] != '0) begin
      op = case_mem[3*i][BYTE_WIDTH-1:0];
      b  = case_mem[3*i+1][BYTE_WIDTH-1:0];
      e  = case_mem[3*i+2][BYTE_WIDTH-1:0];
      case (op)
        8'h01: begin
          apb_write(REG_CONTROL, {4{b}});
          check_read(REG_CONTROL, {4{e}}, "control register");
        end
        8'h02: do_transmit(b, e);
        8'h03: do_receive(b, e, 1'b1);
        8'h04: do_receive(b, e, 1'b0);
        8'h05: do_busy_write(b, e);
        8'h06: check_read(b, to_word(e), "unmapped address");
        default: report_failure("unknown operation code in the case file");
      endcase
      i++;
    end

    repeat (RANDOM_ROUNDS) begin
      random_byte(b);
      do_transmit(b, b);
      random_byte(b);
      do_receive(b, b, 1'b1);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/apb_uart_props.sv
/*
 * Concurrent checks on the APB UART, bound into the top level.
 * Covers the zero-wait ready, the unused slave error and the irq pulse width.
 */

`default_nettype none

module apb_uart_props (
  input logic clk,
  input logic rst_n,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic irq
);

  // Zero wait states
  assert property (@(posedge clk) disable iff (!rst_n) pready == (psel && penable))
    else $error("pready differs from psel and penable");

  assert property (@(posedge clk) disable iff (!rst_n) !pslverr)
    else $error("pslverr went high");

  // irq is a single-cycle pulse
  assert property (@(posedge clk) disable iff (!rst_n) irq |=> !irq)
    else $error("irq stayed high for two cycles");

endmodule

bind apb_uart apb_uart_props apb_uart_props_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .pslverr (pslverr),
  .irq     (irq)
);

`default_nettype wire

// File: hw/apb_uart.sv
/*
 * Top level of the APB UART peripheral.
 * Connects the APB register block to the transmitter and receiver.
 * Slave errors are never signalled.
 */

`default_nettype none

module apb_uart (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [uart_pkg::ADDR_WIDTH-1:0] paddr,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [uart_pkg::DATA_WIDTH-1:0] pwdata,
  output logic [uart_pkg::DATA_WIDTH-1:0] prdata,
  output logic                            pready,
  output logic                            pslverr,
  input  logic                            uart_rx,
  output logic                            uart_tx,
  output logic                            irq
);
  import uart_pkg::*;

  logic [BYTE_WIDTH-1:0] rx_data;
  logic                  rx_valid;
  logic                  rx_error;

  uart_tx_if tx_link ();

  assign pslverr = 1'b0;

  uart_regs uart_regs_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .tx       (tx_link.regs),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .rx_error (rx_error),
    .irq      (irq)
  );

  uart_tx uart_tx_i (
    .clk   (clk),
    .rst_n (rst_n),
    .tx    (tx_link.tx),
    .line  (uart_tx)
  );

  uart_rx uart_rx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .line     (uart_rx),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .rx_error (rx_error)
  );

endmodule

`default_nettype wire

// File: hw/uart/uart_regs.sv
/*
 * APB register block of the UART.
 * Zero-wait-state decode of control, status, transmit and receive registers.
 * A write to the transmit register starts a frame when the transmitter is idle.
 * Status bits 1 to 3 are sticky; irq pulses once per transmit or receive event.
 */

`default_nettype none

module uart_regs (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [uart_pkg::ADDR_WIDTH-1:0] paddr,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [uart_pkg::DATA_WIDTH-1:0] pwdata,
  output logic [uart_pkg::DATA_WIDTH-1:0] prdata,
  output logic                            pready,
  uart_tx_if.regs                         tx,
  input  logic [uart_pkg::BYTE_WIDTH-1:0] rx_data,
  input  logic                            rx_valid,
  input  logic                            rx_error,
  output logic                            irq
);
  import uart_pkg::*;

  logic                  wr_en;
  logic [DATA_WIDTH-1:0] control_q;
  logic [BYTE_WIDTH-1:0] rx_byte_q;
  logic [DATA_WIDTH-1:0] sticky_set;
  logic [DATA_WIDTH-1:0] sticky_clr;
  logic [DATA_WIDTH-1:0] sticky_q;
  logic [DATA_WIDTH-1:0] status_word;

  assign wr_en  = psel && penable && pwrite;
  assign pready = psel && penable;

  // ====================
  // Writable registers
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      control_q   <= '0;
      tx.tx_data  <= '0;
      tx.tx_start <= 1'b0;
    end else begin
      tx.tx_start <= 1'b0;
      if (wr_en && paddr == REG_CONTROL) control_q <= pwdata;
      if (wr_en && paddr == REG_TX_DATA) begin
        tx.tx_data  <= pwdata[BYTE_WIDTH-1:0];
        // Byte is kept but not sent while a frame is running
        tx.tx_start <= !tx.tx_busy;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) rx_byte_q <= '0;
    else if (rx_valid) rx_byte_q <= rx_data;
  end

  // A new event wins over a clear of the sticky status
  always_comb begin
    sticky_set              = '0;
    sticky_set[ST_TX_DONE]  = tx.tx_done;
    sticky_set[ST_RX_VALID] = rx_valid;
    sticky_set[ST_RX_ERROR] = rx_error;
    sticky_clr = (wr_en && paddr == REG_STATUS) ? pwdata : '0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sticky_q <= '0;
      irq      <= 1'b0;
    end else begin
      sticky_q <= (sticky_q & ~sticky_clr) | sticky_set;
      irq      <= tx.tx_done | rx_valid | rx_error;
    end
  end

  always_comb begin
    status_word             = sticky_q;
    status_word[ST_TX_BUSY] = tx.tx_busy;
  end

  // Read mux
  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      case (paddr)
        REG_CONTROL: prdata = control_q;
        REG_STATUS:  prdata = status_word;
        REG_TX_DATA: prdata = {{(DATA_WIDTH - BYTE_WIDTH){1'b0}}, tx.tx_data};
        REG_RX_DATA: prdata = {{(DATA_WIDTH - BYTE_WIDTH){1'b0}}, rx_byte_q};
        default:     prdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/uart/uart_rx.sv
/*
 * UART deserializer, 8 data bits, no parity, one stop bit.
 * The line passes a two-flop synchronizer; a falling edge starts a frame,
 * the start bit is confirmed at half a bit and data is sampled at mid-bit.
 * Emits rx_valid with the byte, or rx_error on a low stop bit.
 */

`default_nettype none

module uart_rx (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            line,
  output logic [uart_pkg::BYTE_WIDTH-1:0] rx_data,
  output logic                            rx_valid,
  output logic                            rx_error
);
  import uart_pkg::*;

  rx_state_e                     state;
  logic                          line_meta;
  logic                          line_sync;
  logic                          line_prev;
  logic [$clog2(BAUD_DIV)-1:0]   baud_cnt;
  logic                          baud_tick;
  logic                          half_tick;
  logic [2:0]                    bit_cnt;
  logic [BYTE_WIDTH-1:0]         shift_q;

  // ====================
  // Input synchronizer
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      line_meta <= 1'b1;
      line_sync <= 1'b1;
      line_prev <= 1'b1;
    end else begin
      line_meta <= line;
      line_sync <= line_meta;
      line_prev <= line_sync;
    end
  end

  assign baud_tick = (baud_cnt == $bits(baud_cnt)'(BAUD_DIV - 1));
  assign half_tick = (baud_cnt == $bits(baud_cnt)'(HALF_BAUD - 1));

  // ====================
  // Frame FSM
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= RX_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
      rx_error <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      rx_error <= 1'b0;
      // Restart at confirmation so later samples sit at mid-bit
      if (state == RX_IDLE || baud_tick || (state == RX_START && half_tick))
        baud_cnt <= '0;
      else
        baud_cnt <= baud_cnt + 1'b1;

      case (state)
        RX_IDLE: begin
          bit_cnt <= '0;
          if (line_prev && !line_sync) state <= RX_START;
        end
        RX_START: begin
          // Glitch rejection
          if (half_tick) state <= line_sync ? RX_IDLE : RX_DATA;
        end
        RX_DATA: begin
          if (baud_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (baud_tick) begin
            rx_valid <= line_sync;
            rx_error <= !line_sync;
            state    <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == RX_DATA && baud_tick) shift_q <= {line_sync, shift_q[BYTE_WIDTH-1:1]};
    if (state == RX_STOP && baud_tick && line_sync) rx_data <= shift_q;
  end

endmodule

`default_nettype wire

// File: hw/uart/uart_tx.sv
/*
 * UART serializer, 8 data bits, no parity, one stop bit.
 * A tx_start pulse launches a frame; the line drops on the next cycle
 * and every bit lasts exactly BAUD_DIV clocks, LSB first.
 */

`default_nettype none

module uart_tx (
  input  logic    clk,
  input  logic    rst_n,
  uart_tx_if.tx   tx,
  output logic    line
);
  import uart_pkg::*;

  tx_state_e                     state;
  logic [$clog2(BAUD_DIV)-1:0]   baud_cnt;
  logic                          baud_tick;
  logic [2:0]                    bit_cnt;
  logic [BYTE_WIDTH-1:0]         shift_q;

  assign baud_tick = (baud_cnt == $bits(baud_cnt)'(BAUD_DIV - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= TX_IDLE;
      baud_cnt   <= '0;
      bit_cnt    <= '0;
      line       <= 1'b1;
      tx.tx_busy <= 1'b0;
      tx.tx_done <= 1'b0;
    end else begin
      tx.tx_done <= 1'b0;
      // Counter restarts with each frame
      if (state == TX_IDLE || baud_tick) baud_cnt <= '0;
      else baud_cnt <= baud_cnt + 1'b1;

      case (state)
        TX_IDLE: begin
          bit_cnt <= '0;
          if (tx.tx_start) begin
            line       <= 1'b0;
            tx.tx_busy <= 1'b1;
            state      <= TX_START;
          end
        end
        TX_START: begin
          if (baud_tick) begin
            line    <= shift_q[0];
            bit_cnt <= '0;
            state   <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (baud_tick) begin
            if (bit_cnt == 3'd7) begin
              line  <= 1'b1;
              state <= TX_STOP;
            end else begin
              line    <= shift_q[0];
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        TX_STOP: begin
          if (baud_tick) begin
            tx.tx_done <= 1'b1;
            tx.tx_busy <= 1'b0;
            state      <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Bit 0 of the shift register is the next bit out
  always_ff @(posedge clk) begin
    if (state == TX_IDLE && tx.tx_start) shift_q <= tx.tx_data;
    else if (baud_tick && state != TX_IDLE) shift_q <= shift_q >> 1;
  end

endmodule

`default_nettype wire

// File: common/uart_tx_if.sv
/*
 * Link between the register block and the transmitter.
 * The register block loads the byte and pulses tx_start;
 * the transmitter reports busy and a done pulse at the end of the stop bit.
 */

`default_nettype none

interface uart_tx_if;
  import uart_pkg::*;

  logic [BYTE_WIDTH-1:0] tx_data;
  logic                  tx_start;
  logic                  tx_busy;
  logic                  tx_done;

  modport regs (
    output tx_data,
    output tx_start,
    input  tx_busy,
    input  tx_done
  );

  modport tx (
    input  tx_data,
    input  tx_start,
    output tx_busy,
    output tx_done
  );

endinterface

`default_nettype wire

// File: common/uart_pkg.sv
/*
 * Shared constants and types for the APB UART peripheral.
 * Holds the line timing, the APB bus widths, the register map,
 * the status bit positions and the FSM state encodings.
 * Modules import it inside their body and use scoped names in port lists.
 */

`default_nettype none

package uart_pkg;

  // ====================
  // Line timing
  // ====================
  localparam int CLK_FREQ  = 16_000_000;
  localparam int BAUD_RATE = 1_000_000;
  localparam int BAUD_DIV  = CLK_FREQ / BAUD_RATE;
  // Start bit confirmation point
  localparam int HALF_BAUD = BAUD_DIV / 2;

  // Bus and character widths
  localparam int ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 32;
  localparam int BYTE_WIDTH = 8;

  // ====================
  // Register map
  // ====================
  localparam logic [ADDR_WIDTH-1:0] REG_CONTROL = 8'h00;
  localparam logic [ADDR_WIDTH-1:0] REG_STATUS  = 8'h04;
  localparam logic [ADDR_WIDTH-1:0] REG_TX_DATA = 8'h08;
  localparam logic [ADDR_WIDTH-1:0] REG_RX_DATA = 8'h0C;

  // Status bits 1 to 3 are sticky and cleared by writing 1
  localparam int ST_TX_BUSY  = 0;
  localparam int ST_TX_DONE  = 1;
  localparam int ST_RX_VALID = 2;
  localparam int ST_RX_ERROR = 3;

  // FSM states
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

endpackage

`default_nettype wire
